// File: icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  icache_pkg::fetch_req_t req,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output icache_pkg::fetch_rsp_t rsp,
    input  logic                   flush_req,
    output logic                   flush_ack,
    output logic                   lookup_en,
    output logic                   alloc_line,
    output logic                   invalidate_all,
    input  logic                   hit,
    input  icache_pkg::word_t      hit_word,
    output logic                   start_refill,
    output logic                   start_bypass,
    output icache_pkg::addr_t      refill_addr,
    input  logic                   done,
    input  icache_pkg::word_t      bypass_word,
    output logic                   ev_hit,
    output logic                   ev_miss,
    output logic                   ev_bypass
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_respond,
        st_refill,
        st_bypass,
        st_flush
    } state_t;

    state_t     state;
    state_t     state_next;
    fetch_req_t req_q;
    logic       uncached_q;
    logic       flush_ack_q;
    logic       accept;
    logic       flush_start;

    // Flush wins over a fetch that arrives in the same idle cycle
    assign flush_start = (state == st_idle) && flush_req;
    assign req_ready   = (state == st_idle) && !flush_req;
    assign accept      = req_valid && req_ready;

    // ------------------------------------------------
    // Next state
    // ------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (flush_start) begin
                    state_next = st_flush;
                end else if (accept) begin
                    state_next = is_cacheable(req.addr) ? st_lookup : st_bypass;
                end
            end
            st_lookup:  state_next = hit ? st_respond : st_refill;
            st_refill:  state_next = done ? st_respond : st_refill;
            st_bypass:  state_next = done ? st_respond : st_bypass;
            st_respond: state_next = rsp_ready ? st_idle : st_respond;
            st_flush:   state_next = flush_req ? st_flush : st_idle;
            default:    state_next = st_idle;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= st_idle;
            uncached_q  <= 1'b0;
            flush_ack_q <= 1'b0;
        end else begin
            state <= state_next;
            if (accept) begin
                uncached_q <= !is_cacheable(req.addr);
            end
            // Ack drops together with the return to idle
            if (flush_start) begin
                flush_ack_q <= 1'b1;
            end else if (state == st_flush && !flush_req) begin
                flush_ack_q <= 1'b0;
            end
        end
    end

    // Request address, held for the whole transaction
    always_ff @(posedge clock) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // ------------------------------------------------
    // Datapath control
    // ------------------------------------------------
    assign lookup_en      = (state == st_lookup);
    assign alloc_line     = lookup_en && !hit;
    assign invalidate_all = flush_start;
    assign start_refill   = alloc_line;
    assign start_bypass   = accept && !is_cacheable(req.addr);
    assign refill_addr    = req_q.addr;

    assign ev_hit    = lookup_en && hit;
    assign ev_miss   = alloc_line;
    assign ev_bypass = start_bypass;

    // After a refill the word comes out of the store
    assign rsp_valid = (state == st_respond);
    assign rsp.data  = uncached_q ? bypass_word : hit_word;
    assign flush_ack = flush_ack_q;

endmodule

// File: icache_perf.sv
`timescale 1ns/1ns

module icache_perf (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     ev_hit,
    input  logic                     ev_miss,
    input  logic                     ev_bypass,
    output icache_pkg::perf_counts_t counts
);

    // Stops at all ones instead of wrapping
    function automatic logic [31:0] sat_inc(logic [31:0] value, logic ev);
        if (ev && value != '1) begin
            return value + 32'd1;
        end
        return value;
    endfunction

    // ------------------------------------------------
    // Event counters
    // ------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            counts.hits     <= '0;
            counts.misses   <= '0;
            counts.bypasses <= '0;
        end else begin
            counts.hits     <= sat_inc(counts.hits, ev_hit);
            counts.misses   <= sat_inc(counts.misses, ev_miss);
            counts.bypasses <= sat_inc(counts.bypasses, ev_bypass);
        end
    end

endmodule

// File: icache_pkg.sv
package icache_pkg;

    // ------------------------------------------------
    // Address and data widths
    // ------------------------------------------------
    localparam int unsigned addr_bits = 32;
    localparam int unsigned word_bits = 32;

    // Byte offset inside one instruction word
    localparam int unsigned byte_offset_bits = 2;

    typedef logic [addr_bits-1:0] addr_t;
    typedef logic [word_bits-1:0] word_t;

    // Top address byte of cacheable memory
    localparam logic [7:0] cacheable_region = 8'ha0;

    // ------------------------------------------------
    // Channel payloads
    // ------------------------------------------------
    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        word_t data;
    } fetch_rsp_t;

    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
    } mem_ar_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } mem_r_t;

    typedef struct packed {
        logic [31:0] hits;
        logic [31:0] misses;
        logic [31:0] bypasses;
    } perf_counts_t;

    // ------------------------------------------------
    // Address field helpers
    // ------------------------------------------------
    function automatic logic is_cacheable(addr_t a);
        return a[addr_bits-1 -: 8] == cacheable_region;
    endfunction

    // First byte of the line holding a
    function automatic addr_t line_base(addr_t a, int unsigned line_words_log2);
        addr_t offset_mask;
        offset_mask = (addr_t'(1) << (byte_offset_bits + line_words_log2)) - addr_t'(1);
        return a & ~offset_mask;
    endfunction

endpackage

// File: icache_refill.sv
`timescale 1ns/1ns

module icache_refill #(
    parameter int line_words_log2 = 2
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       start_refill,
    input  logic                       start_bypass,
    input  icache_pkg::addr_t          addr,
    output logic                       mem_ar_valid,
    input  logic                       mem_ar_ready,
    output icache_pkg::mem_ar_t        mem_ar,
    input  logic                       mem_r_valid,
    output logic                       mem_r_ready,
    input  icache_pkg::mem_r_t         mem_r,
    output logic                       beat_write,
    output logic [line_words_log2-1:0] beat_index,
    output icache_pkg::word_t          beat_data,
    output logic                       done,
    output icache_pkg::word_t          bypass_word
);
    import icache_pkg::*;

    localparam int unsigned line_words = 2 ** line_words_log2;

    logic                       busy_q;
    logic                       ar_pending_q;
    logic                       refill_q;
    logic [line_words_log2-1:0] beat_cnt_q;
    word_t                      bypass_word_q;
    logic                       beat;

    assign beat = mem_r_valid && mem_r_ready;

    // Read request; addr stays stable in the controller until done
    assign mem_ar_valid = ar_pending_q;
    assign mem_ar.addr  = refill_q ? line_base(addr, line_words_log2) : addr;
    assign mem_ar.len   = refill_q ? 8'(line_words - 1) : 8'd0;
    assign mem_r_ready  = busy_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy_q       <= 1'b0;
            ar_pending_q <= 1'b0;
            refill_q     <= 1'b0;
            beat_cnt_q   <= '0;
        end else if (start_refill || start_bypass) begin
            busy_q       <= 1'b1;
            ar_pending_q <= 1'b1;
            refill_q     <= start_refill;
            beat_cnt_q   <= '0;
        end else begin
            if (mem_ar_valid && mem_ar_ready) begin
                ar_pending_q <= 1'b0;
            end
            if (beat) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                if (mem_r.last) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // Single uncached word
    always_ff @(posedge clock) begin
        if (beat && !refill_q) begin
            bypass_word_q <= mem_r.data;
        end
    end

    assign beat_write  = beat && refill_q;
    assign beat_index  = beat_cnt_q;
    assign beat_data   = mem_r.data;
    assign done        = beat && mem_r.last;
    assign bypass_word = bypass_word_q;

endmodule

// File: icache_store.sv
`timescale 1ns/1ns

module icache_store #(
    parameter int index_bits      = 2,
    parameter int line_words_log2 = 2
) (
    input  logic                       clock,
    input  logic                       reset,
    input  icache_pkg::addr_t          addr,
    input  logic                       lookup_en,
    input  logic                       alloc_line,
    input  logic                       invalidate_all,
    input  logic                       beat_write,
    input  logic [line_words_log2-1:0] beat_index,
    input  icache_pkg::word_t          beat_data,
    output logic                       hit,
    output icache_pkg::word_t          hit_word
);
    import icache_pkg::*;

    localparam int unsigned lines      = 2 ** index_bits;
    localparam int unsigned line_words = 2 ** line_words_log2;
    localparam int unsigned index_lsb  = byte_offset_bits + line_words_log2;
    localparam int unsigned tag_lsb    = index_lsb + index_bits;
    localparam int unsigned tag_bits   = addr_bits - tag_lsb;

    logic [lines-1:0]    valid_q;
    logic [tag_bits-1:0] tag_mem [lines];
    word_t               data_mem [lines][line_words];

    logic [index_bits-1:0]      index;
    logic [line_words_log2-1:0] word_sel;
    logic [tag_bits-1:0]        tag;

    // ------------------------------------------------
    // Address split and lookup
    // ------------------------------------------------
    assign word_sel = addr[byte_offset_bits +: line_words_log2];
    assign index    = addr[index_lsb +: index_bits];
    assign tag      = addr[tag_lsb +: tag_bits];

    assign hit      = lookup_en && valid_q[index] && (tag_mem[index] == tag);
    assign hit_word = data_mem[index][word_sel];

    // ------------------------------------------------
    // Valid bits
    // ------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
        end else if (invalidate_all) begin
            valid_q <= '0;
        end else if (alloc_line) begin
            // Line is marked before its data lands; the FSM holds
            // the request until the refill is done
            valid_q[index] <= 1'b1;
        end
    end

    // Tag and data arrays
    always_ff @(posedge clock) begin
        if (alloc_line) begin
            tag_mem[index] <= tag;
        end
        if (beat_write) begin
            data_mem[index][beat_index] <= beat_data;
        end
    end

endmodule

// File: icache_sva.sv
`timescale 1ns/1ns

module icache_sva (
    input logic                   clock,
    input logic                   reset,
    input logic                   req_valid,
    input logic                   req_ready,
    input icache_pkg::fetch_req_t req,
    input logic                   rsp_valid,
    input logic                   rsp_ready,
    input icache_pkg::fetch_rsp_t rsp,
    input logic                   mem_ar_valid,
    input logic                   mem_ar_ready,
    input icache_pkg::mem_ar_t    mem_ar,
    input logic                   flush_req,
    input logic                   flush_ack
);

    // Fetch request held until the cache takes it
    req_stable: assert property (@(posedge clock) disable iff (reset)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("fetch request changed before it was taken");

    // Response held under back-pressure
    rsp_stable: assert property (@(posedge clock) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("fetch response changed before it was taken");

    // Read request held until memory takes it
    ar_stable: assert property (@(posedge clock) disable iff (reset)
        mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_ar))
        else $error("memory read request changed before it was taken");

    no_accept_while_responding: assert property (@(posedge clock) disable iff (reset)
        !(req_ready && rsp_valid))
        else $error("req_ready high while a response is pending");

    ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        $rose(flush_ack) |-> flush_req)
        else $error("flush_ack rose without flush_req");

    ar_idle_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !mem_ar_valid)
        else $error("mem_ar_valid high right after reset");

endmodule

bind icache_top icache_sva sva_inst (.*);

// File: icache_top.sv
`timescale 1ns/1ns

module icache_top #(
    parameter int index_bits      = 2,
    parameter int line_words_log2 = 2
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  icache_pkg::fetch_req_t   req,
    output logic                     rsp_valid,
    input  logic                     rsp_ready,
    output icache_pkg::fetch_rsp_t   rsp,
    output logic                     mem_ar_valid,
    input  logic                     mem_ar_ready,
    output icache_pkg::mem_ar_t      mem_ar,
    input  logic                     mem_r_valid,
    output logic                     mem_r_ready,
    input  icache_pkg::mem_r_t       mem_r,
    input  logic                     flush_req,
    output logic                     flush_ack,
    output icache_pkg::perf_counts_t counts
);
    import icache_pkg::*;

    // ------------------------------------------------
    // Internal wires
    // ------------------------------------------------
    logic                       lookup_en;
    logic                       alloc_line;
    logic                       invalidate_all;
    logic                       hit;
    word_t                      hit_word;
    logic                       start_refill;
    logic                       start_bypass;
    addr_t                      refill_addr;
    logic                       done;
    word_t                      bypass_word;
    logic                       beat_write;
    logic [line_words_log2-1:0] beat_index;
    word_t                      beat_data;
    logic                       ev_hit;
    logic                       ev_miss;
    logic                       ev_bypass;

    icache_ctrl ctrl_inst (
        .clock          (clock),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req            (req),
        .rsp_valid      (rsp_valid),
        .rsp_ready      (rsp_ready),
        .rsp            (rsp),
        .flush_req      (flush_req),
        .flush_ack      (flush_ack),
        .lookup_en      (lookup_en),
        .alloc_line     (alloc_line),
        .invalidate_all (invalidate_all),
        .hit            (hit),
        .hit_word       (hit_word),
        .start_refill   (start_refill),
        .start_bypass   (start_bypass),
        .refill_addr    (refill_addr),
        .done           (done),
        .bypass_word    (bypass_word),
        .ev_hit         (ev_hit),
        .ev_miss        (ev_miss),
        .ev_bypass      (ev_bypass)
    );

    // Store and refill both work from the held request address
    icache_store #(
        .index_bits      (index_bits),
        .line_words_log2 (line_words_log2)
    ) store_inst (
        .clock          (clock),
        .reset          (reset),
        .addr           (refill_addr),
        .lookup_en      (lookup_en),
        .alloc_line     (alloc_line),
        .invalidate_all (invalidate_all),
        .beat_write     (beat_write),
        .beat_index     (beat_index),
        .beat_data      (beat_data),
        .hit            (hit),
        .hit_word       (hit_word)
    );

    icache_refill #(
        .line_words_log2 (line_words_log2)
    ) refill_inst (
        .clock        (clock),
        .reset        (reset),
        .start_refill (start_refill),
        .start_bypass (start_bypass),
        .addr         (refill_addr),
        .mem_ar_valid (mem_ar_valid),
        .mem_ar_ready (mem_ar_ready),
        .mem_ar       (mem_ar),
        .mem_r_valid  (mem_r_valid),
        .mem_r_ready  (mem_r_ready),
        .mem_r        (mem_r),
        .beat_write   (beat_write),
        .beat_index   (beat_index),
        .beat_data    (beat_data),
        .done         (done),
        .bypass_word  (bypass_word)
    );

    icache_perf perf_inst (
        .clock     (clock),
        .reset     (reset),
        .ev_hit    (ev_hit),
        .ev_miss   (ev_miss),
        .ev_bypass (ev_bypass),
        .counts    (counts)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the icache simulation with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_icache -o sim_icache
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_icache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// File: src.f
icache_pkg.sv
icache_ctrl.sv
icache_store.sv
icache_refill.sv
icache_perf.sv
icache_top.sv
icache_sva.sv
tb_icache_mem.sv
tb_icache.sv

// File: tb_icache.sv
`timescale 1ns/1ns

module tb_icache;
    import icache_pkg::*;

    localparam int index_bits      = 2;
    localparam int line_words_log2 = 2;
    localparam int lines           = 2 ** index_bits;
    localparam int timeout_cycles  = 200;
    localparam int num_trans       = 400;

    logic         clock;
    logic         reset;
    logic         req_valid;
    logic         req_ready;
    fetch_req_t   req;
    logic         rsp_valid;
    logic         rsp_ready;
    fetch_rsp_t   rsp;
    logic         mem_ar_valid;
    logic         mem_ar_ready;
    mem_ar_t      mem_ar;
    logic         mem_r_valid;
    logic         mem_r_ready;
    mem_r_t       mem_r;
    logic         flush_req;
    logic         flush_ack;
    perf_counts_t counts;

    int           mem_bursts;
    addr_t        mem_last_addr;
    logic [7:0]   mem_last_len;

    int           errors;
    perf_counts_t expected;
    logic         model_valid [lines];
    logic [31:0]  model_tag [lines];

    icache_top #(
        .index_bits      (index_bits),
        .line_words_log2 (line_words_log2)
    ) icache_top_inst (.*);

    tb_icache_mem mem_inst (
        .clock     (clock),
        .reset     (reset),
        .ar_valid  (mem_ar_valid),
        .ar_ready  (mem_ar_ready),
        .ar        (mem_ar),
        .r_valid   (mem_r_valid),
        .r_ready   (mem_r_ready),
        .r         (mem_r),
        .bursts    (mem_bursts),
        .last_addr (mem_last_addr),
        .last_len  (mem_last_len)
    );

    function automatic word_t word_at(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h3c5a_9e01;
    endfunction

    task automatic expect_equal(string what, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic stop_on_timeout(string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Result: FAILED");
        $finish;
    endtask

    // --------------------------------------------------
    // One fetch, from request to checked response
    // --------------------------------------------------
    task automatic run_fetch(addr_t a);
        int          cycles;
        int          bursts_before;
        int          idx;
        logic [31:0] tag;
        logic        cached;
        logic        predict_hit;
        logic        seen;
        logic        finished;
        word_t       held;
        cached        = (a[31:24] == 8'ha0);
        idx           = int'((a >> (2 + line_words_log2)) % lines);
        tag           = a >> (2 + line_words_log2 + index_bits);
        predict_hit   = cached && model_valid[idx] && (model_tag[idx] == tag);
        bursts_before = mem_bursts;
        req_valid = 1'b1;
        req.addr  = a;
        cycles    = 0;
        #1;
        while (!req_ready) begin
            @(negedge clock);
            cycles++;
            if (cycles > timeout_cycles) stop_on_timeout("req_ready");
            #1;
        end
        @(negedge clock);
        req_valid = 1'b0;
        req.addr  = $urandom;
        cycles    = 1;
        seen      = 1'b0;
        finished  = 1'b0;
        held      = '0;
        while (!finished) begin
            rsp_ready = ($urandom_range(2) != 0);
            #1;
            if (rsp_valid) begin
                if (!seen) begin
                    seen = 1'b1;
                    held = rsp.data;
                    if (predict_hit) expect_equal("hit latency", cycles, 2);
                end
                expect_equal("held response", rsp.data, held);
                finished = rsp_ready;
            end
            if (!finished) begin
                @(negedge clock);
                cycles++;
                if (cycles > timeout_cycles) stop_on_timeout("rsp_valid");
            end
        end
        @(negedge clock);
        rsp_ready = 1'b0;
        #1;
        expect_equal("rsp_valid after transfer", rsp_valid, 0);
        expect_equal("response word", held, word_at(a));
        // Model update and counters
        if (!cached) begin
            expected.bypasses++;
            expect_equal("burst count", mem_bursts, bursts_before + 1);
            expect_equal("bypass address", mem_last_addr, a);
            expect_equal("bypass length", mem_last_len, 0);
        end else if (predict_hit) begin
            expected.hits++;
            expect_equal("burst count", mem_bursts, bursts_before);
        end else begin
            expected.misses++;
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
            expect_equal("burst count", mem_bursts, bursts_before + 1);
            expect_equal("refill address", mem_last_addr,
                         a & ~32'(4 * (2 ** line_words_log2) - 1));
            expect_equal("refill length", mem_last_len, 2 ** line_words_log2 - 1);
        end
        expect_equal("hit counter", counts.hits, expected.hits);
        expect_equal("miss counter", counts.misses, expected.misses);
        expect_equal("bypass counter", counts.bypasses, expected.bypasses);
    endtask

    // Four-phase flush
    task automatic run_flush();
        int cycles;
        expect_equal("flush_ack before request", flush_ack, 0);
        flush_req = 1'b1;
        cycles    = 0;
        #1;
        while (!flush_ack) begin
            @(negedge clock);
            cycles++;
            if (cycles > timeout_cycles) stop_on_timeout("flush_ack to rise");
            #1;
        end
        expect_equal("flush_ack delay", cycles, 1);
        @(negedge clock);
        // Ack stays up until the request drops
        expect_equal("flush_ack held", flush_ack, 1);
        flush_req = 1'b0;
        cycles    = 0;
        #1;
        while (flush_ack) begin
            @(negedge clock);
            cycles++;
            if (cycles > timeout_cycles) stop_on_timeout("flush_ack to fall");
            #1;
        end
        for (int i = 0; i < lines; i++) begin
            model_valid[i] = 1'b0;
        end
        @(negedge clock);
    endtask

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        int pick;
        void'($urandom(15871));
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        flush_req = 1'b0;
        errors    = 0;
        expected  = '0;
        for (int i = 0; i < lines; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        expect_equal("req_ready after reset", req_ready, 1);
        expect_equal("rsp_valid after reset", rsp_valid, 0);
        expect_equal("flush_ack after reset", flush_ack, 0);
        expect_equal("hits after reset", counts.hits, 0);
        expect_equal("misses after reset", counts.misses, 0);
        expect_equal("bypasses after reset", counts.bypasses, 0);

        for (int n = 0; n < num_trans; n++) begin
            pick = $urandom_range(99);
            if (pick < 8) begin
                run_flush();
            end else if (pick < 28) begin
                run_fetch(32'h4000_1000 | ($urandom_range(255) << 2));
            end else begin
                // 256 bytes over a 64 byte cache gives hits and evictions
                run_fetch(32'ha000_0000 | ($urandom_range(63) << 2));
            end
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: tb_icache_mem.sv
`timescale 1ns/1ns

module tb_icache_mem (
    input  logic                clock,
    input  logic                reset,
    input  logic                ar_valid,
    output logic                ar_ready,
    input  icache_pkg::mem_ar_t ar,
    output logic                r_valid,
    input  logic                r_ready,
    output icache_pkg::mem_r_t  r,
    output int                  bursts,
    output icache_pkg::addr_t   last_addr,
    output logic [7:0]          last_len
);
    import icache_pkg::*;

    logic       busy;
    logic       ar_taken;
    logic       r_taken;
    addr_t      base;
    logic [7:0] len;
    logic [7:0] beat;

    // Contents of memory as a function of the byte address
    function automatic word_t word_at(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h3c5a_9e01;
    endfunction

    initial begin
        ar_ready  = 1'b0;
        r_valid   = 1'b0;
        r         = '0;
        bursts    = 0;
        last_addr = '0;
        last_len  = '0;
        busy      = 1'b0;
        ar_taken  = 1'b0;
        r_taken   = 1'b0;
        base      = '0;
        len       = '0;
        beat      = '0;
        forever begin
            @(negedge clock);
            if (reset) begin
                ar_ready = 1'b0;
                r_valid  = 1'b0;
                busy     = 1'b0;
                ar_taken = 1'b0;
                r_taken  = 1'b0;
            end else begin
                if (ar_taken) begin
                    busy      = 1'b1;
                    beat      = '0;
                    bursts    = bursts + 1;
                    last_addr = base;
                    last_len  = len;
                end
                if (r_taken) begin
                    r_valid = 1'b0;
                    if (r.last) begin
                        busy = 1'b0;
                    end
                    beat = beat + 8'd1;
                end
                // Random gaps on both channels
                ar_ready = !busy && ($urandom_range(3) != 0);
                if (busy && !r_valid && ($urandom_range(9) < 7)) begin
                    r_valid = 1'b1;
                    r.data  = word_at(base + {beat, 2'b00});
                    r.last  = (beat == len);
                end
                // Handshakes seen by the next rising edge
                #1;
                ar_taken = ar_valid && ar_ready;
                r_taken  = r_valid && r_ready;
                if (ar_taken) begin
                    base = ar.addr;
                    len  = ar.len;
                end
            end
        end
    end

endmodule
